// File: cache_macros.svh
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// requester address and data widths
`define ADDR_WIDTH 32
`define DATA_WIDTH 64

// one line holds two bus words
`define LINE_BYTES 16

// sets times ways gives 64 lines
`define SET_COUNT 16
`define WAY_COUNT 4

// fixed burst length on both channels
`define BEATS 2

// victim lfsr start value
// any nonzero value keeps the sequence alive
`define LFSR_SEED 1

`endif

// File: cacheGeometryPkg.sv
`include "cache_macros.svh"

package cacheGeometryPkg;

    // address split is tag, set, offset from msb down
    typedef logic [`ADDR_WIDTH-$clog2(`SET_COUNT)-$clog2(`LINE_BYTES)-1:0] tag_t;
    typedef logic [$clog2(`SET_COUNT)-1:0] set_t;
    typedef logic [$clog2(`LINE_BYTES)-1:0] offset_t;

    // one cache line
    // bus side sees two beats, beat 0 is the low half
    // requester side sees sixteen bytes
    typedef union packed {
        logic [`BEATS-1:0][`DATA_WIDTH-1:0] beat;
        logic [`LINE_BYTES-1:0][7:0] bytes;
    } lineWord_t;

    // per-byte write enables, high means write
    typedef logic [`LINE_BYTES-1:0] lineEnable_t;

endpackage

// File: cacheCtrlPkg.sv
`include "cache_macros.svh"

package cacheCtrlPkg;

    // idle, lookup, miss, replace, refill
    typedef enum logic [2:0] {
        stateIdle,
        stateLookup,
        stateMiss,
        stateReplace,
        stateRefill
    } cacheState_t;

    typedef logic [$clog2(`WAY_COUNT)-1:0] way_t;

endpackage

// File: cacheRequestAlign.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheRequestAlign (
    input  logic                          clock,
    input  logic                          reset,
    input  logic                          reqValid,
    input  logic [`ADDR_WIDTH-1:0]        reqAddr,
    input  logic [`DATA_WIDTH-1:0]        reqWdata,
    input  logic [`DATA_WIDTH/8-1:0]      reqWmask,
    output cacheGeometryPkg::tag_t        addrTag,
    output cacheGeometryPkg::set_t        addrSet,
    output cacheGeometryPkg::offset_t     addrOffset,
    output cacheGeometryPkg::lineWord_t   alignedLine,
    output cacheGeometryPkg::lineEnable_t alignedEnable
);
    import cacheGeometryPkg::*;

    // field split by plain bit slicing
    assign addrOffset = reqAddr[$bits(offset_t)-1:0];
    assign addrSet = reqAddr[$bits(offset_t) +: $bits(set_t)];
    assign addrTag = reqAddr[`ADDR_WIDTH-1 -: $bits(tag_t)];

    // move request byte i to line byte offset+i
    always_comb begin
        alignedLine = '0;
        alignedEnable = '0;
        for (int i = 0; i < `DATA_WIDTH/8; i++) begin
            // bytes past the line end are dropped
            if (addrOffset + i < `LINE_BYTES) begin
                alignedLine.bytes[addrOffset + i] = reqWdata[8*i +: 8];
                alignedEnable[addrOffset + i] = reqWmask[i];
            end
        end
    end

    // only 1, 2, 4 or 8 low bytes are legal
    assert property (@(posedge clock) disable iff (reset)
        reqValid |-> reqWmask inside {8'h01, 8'h03, 8'h0f, 8'hff});

endmodule

// File: cacheTagStore.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheTagStore (
    input  logic                   clock,
    input  logic                   reset,
    input  cacheGeometryPkg::tag_t addrTag,
    input  cacheGeometryPkg::set_t addrSet,
    input  cacheCtrlPkg::way_t     chosenWay,
    input  logic                   tagInstall,
    input  logic                   validSet,
    input  logic                   dirtySet,
    input  logic                   dirtyClear,
    input  cacheCtrlPkg::way_t     dirtyWay,
    output logic                   hit,
    output cacheCtrlPkg::way_t     hitWay,
    output logic                   victimDirty,
    output cacheGeometryPkg::tag_t victimTag
);
    import cacheGeometryPkg::*;
    import cacheCtrlPkg::*;

    tag_t tagMem [`SET_COUNT][`WAY_COUNT];
    logic [`WAY_COUNT-1:0] validMem [`SET_COUNT];
    logic [`WAY_COUNT-1:0] dirtyMem [`SET_COUNT];
    // per-way compare result for the indexed set
    logic [`WAY_COUNT-1:0] wayMatch;

    // tag goes in on the last refill beat
    always_ff @(posedge clock) begin
        if (tagInstall) begin
            tagMem[addrSet][chosenWay] <= addrTag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int s = 0; s < `SET_COUNT; s++) begin
                validMem[s] <= '0;
                dirtyMem[s] <= '0;
            end
        end else begin
            if (validSet) begin
                validMem[addrSet][chosenWay] <= 1'b1;
            end
            // write hit marks dirty, finished write-back clears it
            if (dirtySet) begin
                dirtyMem[addrSet][dirtyWay] <= 1'b1;
            end else if (dirtyClear) begin
                dirtyMem[addrSet][dirtyWay] <= 1'b0;
            end
        end
    end

    // all four ways compared in parallel
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < `WAY_COUNT; w++) begin
            wayMatch[w] = validMem[addrSet][w] && (tagMem[addrSet][w] == addrTag);
            if (wayMatch[w]) begin
                hitWay = way_t'(w);
            end
        end
    end

    assign hit = |wayMatch;

    // victim needs write-back only if it holds live modified data
    assign victimDirty = validMem[addrSet][chosenWay] && dirtyMem[addrSet][chosenWay];
    assign victimTag = tagMem[addrSet][chosenWay];

    // refill never installs a tag already present in the set
    assert property (@(posedge clock) disable iff (reset) $onehot0(wayMatch));

endmodule

// File: cacheDataArray.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheDataArray (
    input  logic                          clock,
    input  logic                          reset,
    input  cacheGeometryPkg::set_t        accessSet,
    input  cacheCtrlPkg::way_t            accessWay,
    input  logic                          writeEnable,
    input  cacheGeometryPkg::lineWord_t   writeLine,
    input  cacheGeometryPkg::lineEnable_t writeByteEnable,
    output cacheGeometryPkg::lineWord_t   readLine
);
    import cacheGeometryPkg::*;

    lineWord_t lineMem [`SET_COUNT*`WAY_COUNT];
    // set in the high bits, way in the low bits
    logic [$clog2(`SET_COUNT*`WAY_COUNT)-1:0] lineIndex;

    assign lineIndex = {accessSet, accessWay};

    // byte-masked write
    always_ff @(posedge clock) begin
        if (writeEnable) begin
            for (int b = 0; b < `LINE_BYTES; b++) begin
                if (writeByteEnable[b]) begin
                    lineMem[lineIndex].bytes[b] <= writeLine.bytes[b];
                end
            end
        end
    end

    // read is combinational, same cycle as the index
    assign readLine = lineMem[lineIndex];

    // hit write and refill beat both carry some enabled byte
    assert property (@(posedge clock) disable iff (reset)
        writeEnable |-> writeByteEnable != '0);

endmodule

// File: cacheController.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheController (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     reqValid,
    input  logic                     reqWrite,
    input  logic                     hit,
    input  cacheCtrlPkg::way_t       hitWay,
    input  logic                     victimDirty,
    input  logic                     arReady,
    input  logic                     awReady,
    input  logic                     rValid,
    input  logic                     rLast,
    input  logic                     wReady,
    input  logic                     wLast,
    output cacheCtrlPkg::cacheState_t state,
    output cacheCtrlPkg::way_t       chosenWay,
    output cacheCtrlPkg::way_t       accessWay,
    output logic                     arrayWrite,
    output logic                     refillSelect,
    output logic                     tagInstall,
    output logic                     validSet,
    output logic                     dirtySet,
    output logic                     dirtyClear,
    output logic                     respDone
);
    import cacheCtrlPkg::*;

    cacheState_t nextState;
    logic [15:0] lfsr;
    logic hitWrite;
    logic refillBeat;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= stateIdle;
        end else begin
            state <= nextState;
        end
    end

    // free-running, taps 0 2 3 5
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= 16'(`LFSR_SEED);
        end else begin
            lfsr <= {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        end
    end

    // victim picked once per miss, held through write-back and refill
    always_ff @(posedge clock) begin
        if (reset) begin
            chosenWay <= '0;
        end else if (state == stateLookup && !hit) begin
            chosenWay <= lfsr[$bits(way_t)-1:0];
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stateIdle: begin
                if (reqValid) nextState = stateLookup;
            end
            stateLookup: begin
                nextState = hit ? stateIdle : stateMiss;
            end
            // dirty victim goes out first, then the refill read
            stateMiss: begin
                if (victimDirty && awReady) begin
                    nextState = stateReplace;
                end else if (!victimDirty && arReady) begin
                    nextState = stateRefill;
                end
            end
            stateReplace: begin
                if (wReady && wLast) nextState = stateMiss;
            end
            // back to lookup, which then hits
            stateRefill: begin
                if (rValid && rLast) nextState = stateLookup;
            end
            default: nextState = stateIdle;
        endcase
    end

    assign hitWrite = state == stateLookup && hit && reqWrite;
    assign refillBeat = state == stateRefill && rValid;

    // hit way during lookup, victim way otherwise
    assign accessWay = (state == stateLookup) ? hitWay : chosenWay;
    assign arrayWrite = hitWrite || refillBeat;
    assign refillSelect = state == stateRefill;

    // status updates
    assign tagInstall = refillBeat && rLast;
    assign validSet = refillBeat && rLast;
    assign dirtySet = hitWrite;
    assign dirtyClear = state == stateReplace && wReady && wLast;

    assign respDone = state == stateLookup && hit;

    // the lookup after a refill finds the freshly installed line
    assert property (@(posedge clock) disable iff (reset)
        (state == stateLookup && $past(state) == stateRefill) |-> respDone);

endmodule

// File: cacheBusPort.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheBusPort (
    input  logic                          clock,
    input  logic                          reset,
    input  cacheCtrlPkg::cacheState_t     state,
    input  cacheGeometryPkg::tag_t        addrTag,
    input  cacheGeometryPkg::set_t        addrSet,
    input  cacheGeometryPkg::offset_t     addrOffset,
    input  cacheGeometryPkg::tag_t        victimTag,
    input  logic                          victimDirty,
    input  cacheGeometryPkg::lineWord_t   readLine,
    input  logic                          arReady,
    input  logic                          awReady,
    input  logic                          wReady,
    input  logic [`DATA_WIDTH-1:0]        rData,
    input  logic                          rValid,
    input  logic                          rLast,
    output logic                          arValid,
    output logic [`ADDR_WIDTH-1:0]        arAddr,
    output logic                          awValid,
    output logic [`ADDR_WIDTH-1:0]        awAddr,
    output logic                          wValid,
    output logic [`DATA_WIDTH-1:0]        wData,
    output logic                          wLast,
    output logic                          rReady,
    output cacheGeometryPkg::lineWord_t   refillLine,
    output cacheGeometryPkg::lineEnable_t refillEnable,
    output logic [`DATA_WIDTH-1:0]        respData
);
    import cacheGeometryPkg::*;
    import cacheCtrlPkg::*;

    logic [$clog2(`BEATS)-1:0] beatCount;
    lineWord_t shiftedLine;

    // restarts on each address handshake, steps per data beat
    always_ff @(posedge clock) begin
        if (reset) begin
            beatCount <= '0;
        end else if ((arValid && arReady) || (awValid && awReady)) begin
            beatCount <= '0;
        end else if ((wValid && wReady) || (rValid && rReady)) begin
            beatCount <= beatCount + 1'b1;
        end
    end

    // miss state issues write-back or refill, never both
    assign awValid = state == stateMiss && victimDirty;
    assign arValid = state == stateMiss && !victimDirty;
    assign wValid = state == stateReplace;
    assign rReady = state == stateRefill;

    // line base addresses
    assign awAddr = {victimTag, addrSet, offset_t'(0)};
    assign arAddr = {addrTag, addrSet, offset_t'(0)};

    // victim beats read straight from the array
    assign wData = readLine.beat[beatCount];
    assign wLast = wValid && beatCount == `BEATS-1;

    // same word on both halves, enables pick the half
    always_comb begin
        refillLine.beat = {`BEATS{rData}};
        refillEnable = '0;
        refillEnable[beatCount*(`DATA_WIDTH/8) +: `DATA_WIDTH/8] = '1;
    end

    // response starts at the byte offset
    assign shiftedLine = readLine >> {addrOffset, 3'b000};
    assign respData = shiftedLine.beat[0];

    // memory ends every burst on its second beat
    assert property (@(posedge clock) disable iff (reset)
        rValid && rReady |-> rLast == (beatCount == `BEATS-1));

endmodule

// File: cacheTop.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module cacheTop (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     reqValid,
    input  logic                     reqWrite,
    input  logic [`ADDR_WIDTH-1:0]   reqAddr,
    input  logic [`DATA_WIDTH-1:0]   reqWdata,
    input  logic [`DATA_WIDTH/8-1:0] reqWmask,
    output logic [`DATA_WIDTH-1:0]   respData,
    output logic                     respDone,
    output logic                     arValid,
    output logic [`ADDR_WIDTH-1:0]   arAddr,
    input  logic                     arReady,
    input  logic                     rValid,
    input  logic                     rLast,
    input  logic [`DATA_WIDTH-1:0]   rData,
    output logic                     rReady,
    output logic                     awValid,
    output logic [`ADDR_WIDTH-1:0]   awAddr,
    input  logic                     awReady,
    output logic                     wValid,
    output logic [`DATA_WIDTH-1:0]   wData,
    output logic                     wLast,
    input  logic                     wReady
);
    // request fields
    cacheGeometryPkg::tag_t addrTag;
    cacheGeometryPkg::set_t addrSet;
    cacheGeometryPkg::offset_t addrOffset;
    cacheGeometryPkg::lineWord_t alignedLine;
    cacheGeometryPkg::lineEnable_t alignedEnable;

    // tag store and controller
    logic hit;
    cacheCtrlPkg::way_t hitWay;
    logic victimDirty;
    cacheGeometryPkg::tag_t victimTag;
    cacheCtrlPkg::cacheState_t state;
    cacheCtrlPkg::way_t chosenWay;
    cacheCtrlPkg::way_t accessWay;
    logic arrayWrite;
    logic refillSelect;
    logic tagInstall;
    logic validSet;
    logic dirtySet;
    logic dirtyClear;

    // data path
    cacheGeometryPkg::lineWord_t readLine;
    cacheGeometryPkg::lineWord_t writeLine;
    cacheGeometryPkg::lineEnable_t writeByteEnable;
    cacheGeometryPkg::lineWord_t refillLine;
    cacheGeometryPkg::lineEnable_t refillEnable;

    // refill beat or aligned hit write into the array
    assign writeLine = refillSelect ? refillLine : alignedLine;
    assign writeByteEnable = refillSelect ? refillEnable : alignedEnable;

    cacheRequestAlign requestAlign (.*);

    // dirty bit follows the way being accessed
    cacheTagStore tagStore (.dirtyWay(accessWay), .*);

    cacheDataArray dataArray (.accessSet(addrSet), .writeEnable(arrayWrite), .*);

    cacheController controller (.*);

    cacheBusPort busPort (.*);

endmodule

// File: tbCacheTop.sv
`timescale 1ns/1ps
`include "cache_macros.svh"

module tbCacheTop;
    import cacheGeometryPkg::*;

    // 42 requests of under 40 cycles each fit well inside this limit
    localparam int timeoutCycles = 20000;

    logic clock = 1'b0;
    logic reset;
    logic reqValid;
    logic reqWrite;
    logic [`ADDR_WIDTH-1:0] reqAddr;
    logic [`DATA_WIDTH-1:0] reqWdata;
    logic [`DATA_WIDTH/8-1:0] reqWmask;
    logic [`DATA_WIDTH-1:0] respData;
    logic respDone;
    logic arValid;
    logic [`ADDR_WIDTH-1:0] arAddr;
    logic arReady;
    logic rValid;
    logic rLast;
    logic [`DATA_WIDTH-1:0] rData;
    logic rReady;
    logic awValid;
    logic [`ADDR_WIDTH-1:0] awAddr;
    logic awReady;
    logic wValid;
    logic [`DATA_WIDTH-1:0] wData;
    logic wLast;
    logic wReady;

    // memory behind the bus, and what the requester should see
    logic [7:0] memBytes [logic [31:0]];
    logic [7:0] shadowBytes [logic [31:0]];
    int readBursts = 0;
    int writeBacks = 0;
    logic [31:0] lastReadAddr = '0;
    logic [63:0] firstReadData;
    int cycleCount = 0;
    int errorCount = 0;
    int errorsAtStart;
    int testsPassed = 0;
    int testsFailed = 0;
    string currentTest = "setup";

    cacheTop DUT (.*);

    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycleCount++;
        if (cycleCount >= timeoutCycles) begin
            $display("timeout: run stopped after %0d cycles in %s", cycleCount, currentTest);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // untouched memory depends on every address bit
    function automatic logic [7:0] fillByte(input logic [31:0] addr);
        return addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ 8'h5a;
    endfunction

    // one line from the shadow or from bus memory
    function automatic lineWord_t lineFrom(input logic fromShadow, input logic [31:0] base);
        lineWord_t line;
        logic [31:0] a;
        for (int i = 0; i < `LINE_BYTES; i++) begin
            a = base + 32'(i);
            if (fromShadow && shadowBytes.exists(a)) begin
                line.bytes[i] = shadowBytes[a];
            end else if (!fromShadow && memBytes.exists(a)) begin
                line.bytes[i] = memBytes[a];
            end else begin
                line.bytes[i] = fillByte(a);
            end
        end
        return line;
    endfunction

    // aligned 8-byte word at offset 0 or 8
    function automatic logic [63:0] expectedWord(input logic [31:0] addr);
        lineWord_t line;
        line = lineFrom(1'b1, {addr[31:4], 4'h0});
        return line.beat[addr[3]];
    endfunction

    task automatic checkValue(input string what, input logic [63:0] expected,
                              input logic [63:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("** Error %s %s: expected %h, actual %h",
                     currentTest, what, expected, actual);
        end
    endtask

    task automatic startTest(input string name);
        currentTest = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        if (errorCount == errorsAtStart) begin
            testsPassed++;
            $display("%s: ok", currentTest);
        end else begin
            testsFailed++;
            $display("%s: failed with %0d errors", currentTest, errorCount - errorsAtStart);
        end
    endtask

    task automatic randomWait();
        repeat ($urandom % 4) begin
            @(posedge clock);
            #1;
        end
    endtask

    // read burst from bus memory
    task automatic serveRead();
        logic [31:0] base;
        lineWord_t line;
        base = arAddr;
        line = lineFrom(1'b0, base);
        readBursts++;
        lastReadAddr = base;
        randomWait();
        // request must stay put while the memory stalls
        checkValue("arValid held", 1, arValid);
        checkValue("arAddr held", base, arAddr);
        arReady = 1'b1;
        @(posedge clock);
        #1;
        arReady = 1'b0;
        for (int b = 0; b < `BEATS; b++) begin
            randomWait();
            checkValue("rReady", 1, rReady);
            rValid = 1'b1;
            rLast = (b == `BEATS-1);
            rData = line.beat[b];
            @(posedge clock);
            #1;
            rValid = 1'b0;
            rLast = 1'b0;
        end
    endtask

    // write-back burst, checked beat by beat against the shadow
    task automatic serveWrite();
        logic [31:0] base;
        lineWord_t expected;
        lineWord_t written;
        base = awAddr;
        expected = lineFrom(1'b1, base);
        writeBacks++;
        checkValue("write-back address offset", 0, base[3:0]);
        randomWait();
        checkValue("awValid held", 1, awValid);
        checkValue("awAddr held", base, awAddr);
        awReady = 1'b1;
        @(posedge clock);
        #1;
        awReady = 1'b0;
        for (int b = 0; b < `BEATS; b++) begin
            randomWait();
            wReady = 1'b1;
            checkValue("wValid", 1, wValid);
            checkValue($sformatf("write-back %h beat %0d", base, b), expected.beat[b], wData);
            checkValue("wLast", b == `BEATS-1, wLast);
            written.beat[b] = wData;
            @(posedge clock);
            #1;
            wReady = 1'b0;
        end
        for (int i = 0; i < `LINE_BYTES; i++) begin
            memBytes[base + 32'(i)] = written.bytes[i];
        end
    endtask

    initial begin
        arReady = 1'b0;
        rValid = 1'b0;
        rLast = 1'b0;
        rData = '0;
        forever begin
            @(posedge clock);
            #1;
            if (!reset && arValid) begin
                serveRead();
            end
        end
    end

    initial begin
        awReady = 1'b0;
        wReady = 1'b0;
        forever begin
            @(posedge clock);
            #1;
            if (!reset && awValid) begin
                serveWrite();
            end
        end
    end

    // one request, held until done, dropped in the next cycle
    task automatic access(input logic write, input logic [31:0] addr,
                          input logic [63:0] wdata, input logic [7:0] mask,
                          output logic [63:0] rdata);
        reqValid = 1'b1;
        reqWrite = write;
        reqAddr = addr;
        reqWdata = wdata;
        reqWmask = mask;
        @(posedge clock);
        #1;
        while (!respDone) begin
            @(posedge clock);
            #1;
        end
        rdata = respData;
        @(posedge clock);
        #1;
        reqValid = 1'b0;
        if (write) begin
            for (int i = 0; i < 8; i++) begin
                if (mask[i]) begin
                    shadowBytes[addr + 32'(i)] = wdata[8*i +: 8];
                end
            end
        end
    endtask

    task automatic idleAfterReset();
        startTest("idleAfterReset");
        repeat (10) begin
            @(posedge clock);
            #1;
            checkValue("respDone", 0, respDone);
            checkValue("arValid", 0, arValid);
            checkValue("awValid", 0, awValid);
            checkValue("wValid", 0, wValid);
            checkValue("rReady", 0, rReady);
        end
        finishTest();
    endtask

    task automatic freshRead();
        int burstsBefore;
        startTest("freshRead");
        burstsBefore = readBursts;
        access(1'b0, 32'h0000_1238, '0, 8'hff, firstReadData);
        checkValue("read bursts", 1, readBursts - burstsBefore);
        checkValue("burst address", 32'h0000_1230, lastReadAddr);
        checkValue("read data", expectedWord(32'h0000_1238), firstReadData);
        finishTest();
    endtask

    task automatic repeatRead();
        int burstsBefore;
        int writeBacksBefore;
        logic [63:0] data;
        startTest("repeatRead");
        burstsBefore = readBursts;
        writeBacksBefore = writeBacks;
        access(1'b0, 32'h0000_1238, '0, 8'hff, data);
        checkValue("read bursts", 0, readBursts - burstsBefore);
        checkValue("write-backs", 0, writeBacks - writeBacksBefore);
        checkValue("read data", firstReadData, data);
        finishTest();
    endtask

    task automatic writeHits();
        int offsets [6] = '{8, 0, 3, 6, 12, 15};
        logic [7:0] masks [6] = '{8'hff, 8'hff, 8'h01, 8'h03, 8'h0f, 8'h01};
        int burstsBefore;
        logic [63:0] data;
        startTest("writeHits");
        burstsBefore = readBursts;
        // overlapping writes on the resident line
        for (int i = 0; i < 6; i++) begin
            access(1'b1, 32'h0000_1230 + 32'(offsets[i]), {$urandom, $urandom}, masks[i], data);
        end
        checkValue("read bursts", 0, readBursts - burstsBefore);
        access(1'b0, 32'h0000_1230, '0, 8'hff, data);
        checkValue("low half", expectedWord(32'h0000_1230), data);
        access(1'b0, 32'h0000_1238, '0, 8'hff, data);
        checkValue("high half", expectedWord(32'h0000_1238), data);
        finishTest();
    endtask

    task automatic evictionSweep();
        int writeBacksBefore;
        logic [31:0] addr;
        logic [63:0] data;
        startTest("evictionSweep");
        writeBacksBefore = writeBacks;
        // eight tags in set 9, only four ways
        for (int k = 0; k < 8; k++) begin
            addr = 32'h0004_0090 + 32'(k) * 32'h100;
            access(1'b1, addr, {$urandom, $urandom}, 8'hff, data);
            access(1'b1, addr + 32'd8, {$urandom, $urandom}, 8'h0f, data);
        end
        checkValue("at least four write-backs", 1, (writeBacks - writeBacksBefore) >= 4);
        for (int k = 0; k < 8; k++) begin
            addr = 32'h0004_0090 + 32'(k) * 32'h100;
            access(1'b0, addr, '0, 8'hff, data);
            checkValue($sformatf("line %0d low", k), expectedWord(addr), data);
            access(1'b0, addr + 32'd8, '0, 8'hff, data);
            checkValue($sformatf("line %0d high", k), expectedWord(addr + 32'd8), data);
        end
        finishTest();
    endtask

    initial begin
        void'($urandom(1));
        reset = 1'b1;
        reqValid = 1'b0;
        reqWrite = 1'b0;
        reqAddr = '0;
        reqWdata = '0;
        reqWmask = 8'hff;
        repeat (8) @(posedge clock);
        #1;
        reset = 1'b0;

        idleAfterReset();
        freshRead();
        repeatRead();
        writeHits();
        evictionSweep();

        $display("tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: cacheTop.f
+incdir+.
cacheGeometryPkg.sv
cacheCtrlPkg.sv
cacheRequestAlign.sv
cacheTagStore.sv
cacheDataArray.sv
cacheController.sv
cacheBusPort.sv
cacheTop.sv
tbCacheTop.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the cache testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f cacheTop.f \
    --top-module tbCacheTop \
    -o simCache

./obj_dir/simCache | tee sim.log

if grep -q "RESULT: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
